// File: logic/excp_pkg.sv
`default_nettype none

package excp_pkg;

    // ==============================
    // Widths
    // ==============================
    typedef logic [31:0] word_t;
    typedef logic [7:0]  excp_flags_t;
    typedef logic [4:0]  exccode_t;
    typedef logic [1:0]  cp0_sel_t;

    // Per-slot exception flag positions
    localparam int FLAG_STORE_ADE = 0;
    localparam int FLAG_LOAD_ADE  = 1;
    localparam int FLAG_OVERFLOW  = 2;
    localparam int FLAG_RESERVED  = 3;
    localparam int FLAG_ERET      = 4;
    localparam int FLAG_BREAK     = 5;
    localparam int FLAG_SYSCALL   = 6;
    localparam int FLAG_FETCH_ADE = 7;

    // Cause.ExcCode values
    localparam exccode_t EXC_INT  = 5'd0;
    localparam exccode_t EXC_ADEL = 5'd4;
    localparam exccode_t EXC_ADES = 5'd5;
    localparam exccode_t EXC_SYS  = 5'd8;
    localparam exccode_t EXC_BP   = 5'd9;
    localparam exccode_t EXC_RI   = 5'd10;
    localparam exccode_t EXC_OV   = 5'd12;
    localparam exccode_t EXC_ERET = 5'd14; // Redirect only, never lands in Cause

    localparam cp0_sel_t SEL_STATUS   = 2'd0;
    localparam cp0_sel_t SEL_CAUSE    = 2'd1;
    localparam cp0_sel_t SEL_EPC      = 2'd2;
    localparam cp0_sel_t SEL_BADVADDR = 2'd3;

    localparam word_t EXC_VECTOR   = 32'hBFC0_0380;
    localparam word_t STATUS_RESET = 32'h0040_0000; // BEV set
    localparam int    STATUS_IE    = 0;
    localparam int    STATUS_EXL   = 1;
    localparam int    CAUSE_BD     = 31;

    // ==============================
    // Bundles
    // ==============================
    typedef struct packed {
        logic        valid;
        logic        in_delayslot;
        excp_flags_t flags;
        word_t       pc;
        word_t       daddr; // Master slot only
    } slot_t;

    typedef struct packed {
        slot_t    master;
        slot_t    slave;
        logic     mtc0_en;
        cp0_sel_t mtc0_sel;
        word_t    mtc0_data;
    } commit_t;

    typedef struct packed {
        word_t status;
        word_t cause;
        word_t epc;
        word_t badvaddr;
    } cp0_view_t;

    typedef struct packed {
        logic     take;
        logic     is_eret;
        exccode_t code;
        word_t    epc_pc;
        logic     in_delayslot;
        logic     bad_addr_en;
        word_t    bad_addr;
        word_t    target;
    } excp_decision_t;

    typedef struct packed {
        logic     redirect;
        exccode_t code;
        word_t    target;
    } outcome_t;

endpackage

`default_nettype wire

// File: logic/commit_capture.sv
`timescale 1ns/1ps
`default_nettype none

module commit_capture (
    input  logic              clk,
    input  logic              rst_n,
    input  excp_pkg::commit_t commit_data,
    input  logic              commit_valid,
    output logic              commit_ready,
    output excp_pkg::commit_t cap_data,
    output logic              cap_valid,
    input  logic              retire
);

    logic              full;
    excp_pkg::commit_t held;
    logic              accept;

    assign commit_ready = !full || retire; // Refill on the retire edge
    assign accept       = commit_valid && commit_ready;
    assign cap_valid    = full;
    assign cap_data     = held;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (retire) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held <= commit_data;
        end
    end

    // ==============================
    // Checks
    // ==============================
    // Source must hold the bundle while it waits
    property p_commit_stable;
        @(posedge clk) disable iff (!rst_n)
        commit_valid && !commit_ready |=> $stable(commit_data);
    endproperty

    a_commit_stable : assert property (p_commit_stable)
        else $error("commit_data changed while stalled");

endmodule

`default_nettype wire

// File: logic/exception_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module exception_resolve (
    input  excp_pkg::commit_t        cap_data,
    input  logic                     cap_valid,
    input  excp_pkg::cp0_view_t      cp0,
    output excp_pkg::excp_decision_t decision
);

    excp_pkg::slot_t       master;
    excp_pkg::slot_t       slave;
    excp_pkg::excp_flags_t master_flags;
    excp_pkg::excp_flags_t slave_flags;
    excp_pkg::excp_flags_t flags;
    logic                  use_master;
    logic                  live;
    logic                  int_pending;

    assign master = cap_data.master;
    assign slave  = cap_data.slave;

    // Flags of an empty slot do not count
    assign master_flags = master.valid ? master.flags : '0;
    assign slave_flags  = slave.valid ? slave.flags : '0;

    assign use_master = (|master_flags) || !(|slave_flags); // Master wins ties
    assign flags      = use_master ? master_flags : slave_flags;
    assign live       = cap_valid && (master.valid || slave.valid);

    assign int_pending = master.valid
                      && (|(cp0.cause[15:8] & cp0.status[15:8]))
                      && !cp0.status[excp_pkg::STATUS_EXL]
                      && cp0.status[excp_pkg::STATUS_IE];

    // ==============================
    // Priority encoder
    // ==============================
    always_comb begin
        decision              = '0;
        decision.code         = excp_pkg::EXC_INT;
        decision.epc_pc       = use_master ? master.pc : slave.pc;
        decision.in_delayslot = use_master ? master.in_delayslot : slave.in_delayslot;
        decision.target       = excp_pkg::EXC_VECTOR;
        if (live) begin
            decision.take = 1'b1;
            if (int_pending) begin
                decision.code         = excp_pkg::EXC_INT;
                decision.epc_pc       = master.pc; // Interrupt lands on master
                decision.in_delayslot = master.in_delayslot;
            end else if (flags[excp_pkg::FLAG_LOAD_ADE]) begin
                decision.code        = excp_pkg::EXC_ADEL;
                decision.bad_addr_en = 1'b1;
                decision.bad_addr    = master.daddr;
            end else if (flags[excp_pkg::FLAG_FETCH_ADE]) begin
                decision.code        = excp_pkg::EXC_ADEL;
                decision.bad_addr_en = 1'b1;
                decision.bad_addr    = decision.epc_pc; // Faulting fetch address
            end else if (flags[excp_pkg::FLAG_STORE_ADE]) begin
                decision.code        = excp_pkg::EXC_ADES;
                decision.bad_addr_en = 1'b1;
                decision.bad_addr    = master.daddr;
            end else if (flags[excp_pkg::FLAG_SYSCALL]) begin
                decision.code = excp_pkg::EXC_SYS;
            end else if (flags[excp_pkg::FLAG_BREAK]) begin
                decision.code = excp_pkg::EXC_BP;
            end else if (flags[excp_pkg::FLAG_ERET]) begin
                decision.code    = excp_pkg::EXC_ERET;
                decision.is_eret = 1'b1;
                decision.target  = cp0.epc; // Return path
            end else if (flags[excp_pkg::FLAG_RESERVED]) begin
                decision.code = excp_pkg::EXC_RI;
            end else if (flags[excp_pkg::FLAG_OVERFLOW]) begin
                decision.code = excp_pkg::EXC_OV;
            end else begin
                decision.take = 1'b0; // Clean bundle
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/cp0_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     retire,
    input  excp_pkg::excp_decision_t decision,
    input  excp_pkg::commit_t        cap_data,
    input  logic [5:0]               hw_int,
    output excp_pkg::cp0_view_t      cp0
);

    excp_pkg::word_t status;
    excp_pkg::word_t cause;
    excp_pkg::word_t epc;
    excp_pkg::word_t badvaddr;
    logic            excp_commit;
    logic            eret_commit;
    logic            mtc0_commit;

    assign excp_commit = retire && decision.take && !decision.is_eret;
    assign eret_commit = retire && decision.take && decision.is_eret;
    assign mtc0_commit = retire && !decision.take && cap_data.mtc0_en; // Redirect cancels MTC0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status   <= excp_pkg::STATUS_RESET;
            cause    <= '0;
            epc      <= '0;
            badvaddr <= '0;
        end else begin
            cause[15:10] <= hw_int; // IP7..IP2 follow the pins
            if (excp_commit) begin
                status[excp_pkg::STATUS_EXL] <= 1'b1;
                cause[excp_pkg::CAUSE_BD]    <= decision.in_delayslot;
                cause[6:2]                   <= decision.code;
                epc <= decision.in_delayslot ? decision.epc_pc - 32'd4 : decision.epc_pc;
                if (decision.bad_addr_en) begin
                    badvaddr <= decision.bad_addr;
                end
            end else if (eret_commit) begin
                status[excp_pkg::STATUS_EXL] <= 1'b0;
            end else if (mtc0_commit) begin
                case (cap_data.mtc0_sel)
                    excp_pkg::SEL_STATUS:   status     <= cap_data.mtc0_data;
                    excp_pkg::SEL_CAUSE:    cause[9:8] <= cap_data.mtc0_data[9:8]; // Soft IP only
                    excp_pkg::SEL_EPC:      epc        <= cap_data.mtc0_data;
                    excp_pkg::SEL_BADVADDR: badvaddr   <= cap_data.mtc0_data;
                    default:                status     <= status;
                endcase
            end
        end
    end

    assign cp0.status   = status;
    assign cp0.cause    = cause;
    assign cp0.epc      = epc;
    assign cp0.badvaddr = badvaddr;

    // ==============================
    // Checks
    // ==============================
    // ERET only returns from exception level
    property p_eret_in_exl;
        @(posedge clk) disable iff (!rst_n)
        eret_commit |-> status[excp_pkg::STATUS_EXL];
    endproperty

    a_eret_in_exl : assert property (p_eret_in_exl)
        else $error("ERET retired while EXL was clear");

endmodule

`default_nettype wire

// File: logic/redirect_out.sv
`timescale 1ns/1ps
`default_nettype none

module redirect_out (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cap_valid,
    input  excp_pkg::excp_decision_t decision,
    output logic                     retire,
    output excp_pkg::outcome_t       out_data,
    output logic                     out_valid,
    input  logic                     out_ready
);

    logic               full;
    excp_pkg::outcome_t held;

    assign retire    = cap_valid && (!full || out_ready); // Slot free or draining
    assign out_valid = full;
    assign out_data  = held;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (retire) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;
        end
    end

    // No redirect reports zero code and target
    always_ff @(posedge clk) begin
        if (retire) begin
            held.redirect <= decision.take;
            held.code     <= decision.take ? decision.code : '0;
            held.target   <= decision.take ? decision.target : '0;
        end
    end

    property p_out_stable;
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data);
    endproperty

    a_out_stable : assert property (p_out_stable)
        else $error("out_data changed while stalled");

endmodule

`default_nettype wire

// File: logic/excp_top.sv
`timescale 1ns/1ps
`default_nettype none

module excp_top (
    input  logic                clk,
    input  logic                rst_n,
    input  excp_pkg::commit_t   commit_data,
    input  logic                commit_valid,
    output logic                commit_ready,
    input  logic [5:0]          hw_int,
    output excp_pkg::outcome_t  out_data,
    output logic                out_valid,
    input  logic                out_ready,
    output excp_pkg::cp0_view_t cp0
);

    excp_pkg::commit_t        cap_data;
    logic                     cap_valid;
    excp_pkg::excp_decision_t decision;
    logic                     retire;

    commit_capture i_capture (
        .clk          (clk),
        .rst_n        (rst_n),
        .commit_data  (commit_data),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .cap_data     (cap_data),
        .cap_valid    (cap_valid),
        .retire       (retire)
    );

    exception_resolve i_resolve (
        .cap_data  (cap_data),
        .cap_valid (cap_valid),
        .cp0       (cp0),
        .decision  (decision)
    );

    cp0_regs i_cp0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .retire   (retire),
        .decision (decision),
        .cap_data (cap_data),
        .hw_int   (hw_int),
        .cp0      (cp0)
    );

    redirect_out i_out (
        .clk       (clk),
        .rst_n     (rst_n),
        .cap_valid (cap_valid),
        .decision  (decision),
        .retire    (retire),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// File: bench/excp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module excp_tb;

    localparam int NUM_RECORDS    = 27;
    localparam int WORDS          = 13; // Words per golden record
    localparam int TIMEOUT_CYCLES = 4 * NUM_RECORDS + 20;

    // ==============================
    // Golden columns
    // ==============================
    localparam int C_M_CTL   = 0;
    localparam int C_M_PC    = 1;
    localparam int C_M_DADDR = 2;
    localparam int C_S_CTL   = 3;
    localparam int C_S_PC    = 4;
    localparam int C_MTC0    = 5;
    localparam int C_MTC0_D  = 6;
    localparam int C_HW_INT  = 7;
    localparam int C_OUT     = 8;
    localparam int C_TARGET  = 9;
    localparam int C_EPC     = 10;
    localparam int C_CAUSE   = 11;
    localparam int C_BADVA   = 12;

    logic                clk;
    logic                rst_n;
    excp_pkg::commit_t   commit_data;
    logic                commit_valid;
    logic                commit_ready;
    logic [5:0]          hw_int;
    excp_pkg::outcome_t  out_data;
    logic                out_valid;
    logic                out_ready;
    excp_pkg::cp0_view_t cp0;

    excp_pkg::word_t golden [NUM_RECORDS * WORDS];
    int              consumed; // Outcomes taken off the result channel
    int              cycles;
    excp_pkg::word_t exp_status;

    excp_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .commit_data  (commit_data),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .hw_int       (hw_int),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .cp0          (cp0)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input excp_pkg::word_t exp,
                               input excp_pkg::word_t got);
        assert (got === exp)
            else fail_run($sformatf("ERROR %s: expected %h, got %h", name, exp, got));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic excp_pkg::slot_t slot_from(input excp_pkg::word_t ctl,
                                                  input excp_pkg::word_t pc,
                                                  input excp_pkg::word_t daddr);
        excp_pkg::slot_t s;
        s.valid        = ctl[9];
        s.in_delayslot = ctl[8];
        s.flags        = ctl[7:0];
        s.pc           = pc;
        s.daddr        = daddr;
        return s;
    endfunction

    function automatic excp_pkg::commit_t bundle_from(input int k);
        excp_pkg::commit_t b;
        int                base;
        base        = k * WORDS;
        b.master    = slot_from(golden[base + C_M_CTL], golden[base + C_M_PC],
                                golden[base + C_M_DADDR]);
        b.slave     = slot_from(golden[base + C_S_CTL], golden[base + C_S_PC], '0);
        b.mtc0_en   = golden[base + C_MTC0][4];
        b.mtc0_sel  = golden[base + C_MTC0][1:0];
        b.mtc0_data = golden[base + C_MTC0_D];
        return b;
    endfunction

    task automatic check_record(input int k, input excp_pkg::outcome_t got,
                                input excp_pkg::cp0_view_t snap);
        int base;
        base = k * WORDS;
        check_value("out_data.redirect", golden[base + C_OUT][8], got.redirect);
        check_value("out_data.code", golden[base + C_OUT][4:0], got.code);
        check_value("out_data.target", golden[base + C_TARGET], got.target);
        check_value("cp0.epc", golden[base + C_EPC], snap.epc);
        check_value("cp0.cause", golden[base + C_CAUSE], snap.cause);
        check_value("cp0.badvaddr", golden[base + C_BADVA], snap.badvaddr);
        // Status follows EXL on redirects and MTC0 on clean bundles
        if (golden[base + C_OUT][8]) begin
            exp_status[excp_pkg::STATUS_EXL] =
                golden[base + C_OUT][4:0] != excp_pkg::EXC_ERET;
        end else if (golden[base + C_MTC0][4]
                     && golden[base + C_MTC0][1:0] == excp_pkg::SEL_STATUS) begin
            exp_status = golden[base + C_MTC0_D];
        end
        check_value("cp0.status", exp_status, snap.status);
    endtask

    // ==============================
    // Producer and consumer
    // ==============================
    task automatic push_records();
        int k;
        for (k = 0; k < NUM_RECORDS; k++) begin
            if (golden[k * WORDS + C_HW_INT][5:0] !== hw_int) begin
                // Interrupt lines only move with the pipeline empty
                commit_valid = 1'b0;
                while (consumed != k) begin
                    @(posedge clk);
                    #2;
                end
                hw_int = golden[k * WORDS + C_HW_INT][5:0];
            end
            commit_data  = bundle_from(k);
            commit_valid = 1'b1;
            @(posedge clk);
            while (!commit_ready) begin
                @(posedge clk);
            end
            #2;
        end
        commit_valid = 1'b0;
    endtask

    task automatic collect_outcomes();
        logic [31:0]         seed;
        excp_pkg::outcome_t  got;
        excp_pkg::outcome_t  stalled;
        excp_pkg::cp0_view_t snap;
        logic                was_stalled;
        logic                pending;
        seed        = 32'd58170;
        was_stalled = 1'b0;
        pending     = 1'b0;
        while (consumed < NUM_RECORDS || pending) begin
            @(posedge clk);
            if (was_stalled) begin
                assert (out_valid && out_data === stalled)
                    else fail_run("outcome changed or vanished while out_ready was low");
            end
            if (pending) begin
                check_record(consumed - 1, got, snap);
                pending = 1'b0;
            end
            if (out_valid && out_ready) begin
                assert (consumed < NUM_RECORDS)
                    else fail_run("outcome arrived beyond the last record");
                got      = out_data;
                snap     = cp0; // CP0 before the next bundle retires
                pending  = 1'b1;
                consumed = consumed + 1;
            end
            was_stalled = out_valid && !out_ready;
            stalled     = out_data;
            #2;
            seed      = xorshift32(seed);
            out_ready = (seed % 3) != 0; // Stall about one cycle in three
        end
        out_ready = 1'b1;
        repeat (3) begin
            @(posedge clk);
            assert (!out_valid) else fail_run("outcome arrived beyond the last record");
        end
    endtask

    initial begin
        int k;
        commit_data  = '0;
        commit_valid = 1'b0;
        hw_int       = '0;
        out_ready    = 1'b1;
        consumed     = 0;
        exp_status   = 32'h0040_0000;
        rst_n        = 1'b0;
        $readmemh("bench/excp_golden.txt", golden);
        for (k = 0; k < NUM_RECORDS * WORDS; k++) begin
            assert (!$isunknown(golden[k]))
                else fail_run("golden file bench/excp_golden.txt is missing or short");
        end
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        fork
            push_records();
            collect_outcomes();
        join
        $display("TEST OK");
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        fail_run("timeout: outcomes missing");
    end

endmodule

`default_nettype wire

// File: bench/excp_golden.txt
// m_ctl m_pc m_daddr s_ctl s_pc mtc0 mtc0_data hw_int out target epc cause badvaddr
// ctl: bit 9 valid, bit 8 delay slot, 7:0 flags | mtc0: bit 4 en, 1:0 sel | out: bit 8 redirect
200 80000000 00000000 000 00000000 12 80000100 00 000 00000000 80000100 00000000 00000000
000 00000000 00000000 000 00000000 13 12345678 00 000 00000000 80000100 00000000 12345678
240 80000200 00000000 220 80000204 00 00000000 00 108 bfc00380 80000200 00000020 12345678
210 80000300 00000000 000 00000000 00 00000000 00 10e 80000200 80000200 00000020 12345678
200 80000400 00000000 204 80000404 00 00000000 00 10c bfc00380 80000404 00000030 12345678
210 80000500 00000000 000 00000000 00 00000000 00 10e 80000404 80000404 00000030 12345678
320 80000608 00000000 000 00000000 00 00000000 00 109 bfc00380 80000604 80000024 12345678
210 80000700 00000000 000 00000000 00 00000000 00 10e 80000604 80000604 80000024 12345678
240 80000800 00000000 000 00000000 00 00000000 00 108 bfc00380 80000800 00000020 12345678
2c2 80000900 00001001 000 00000000 00 00000000 00 104 bfc00380 80000900 00000010 00001001
2a1 80000a03 00002002 000 00000000 00 00000000 00 104 bfc00380 80000a03 00000010 80000a03
245 80000b00 00003006 000 00000000 00 00000000 00 105 bfc00380 80000b00 00000014 00003006
238 80000c00 00000000 000 00000000 00 00000000 00 109 bfc00380 80000c00 00000024 00003006
21c 80000d00 00000000 000 00000000 00 00000000 00 10e 80000c00 80000c00 00000024 00003006
200 80000e00 00000000 30c 80000e04 00 00000000 00 10a bfc00380 80000e00 80000028 00003006
210 80000f00 00000000 000 00000000 00 00000000 00 10e 80000e00 80000e00 80000028 00003006
200 80001000 00000000 000 00000000 10 00400401 00 000 00000000 80000e00 80000028 00003006
200 80001100 00000000 000 00000000 00 00000000 01 100 bfc00380 80001100 00000400 00003006
200 80001200 00000000 000 00000000 00 00000000 01 000 00000000 80001100 00000400 00003006
240 80001300 00000000 000 00000000 00 00000000 01 108 bfc00380 80001300 00000420 00003006
210 80001400 00000000 000 00000000 00 00000000 01 10e 80001300 80001300 00000420 00003006
202 80001500 00005005 000 00000000 00 00000000 01 100 bfc00380 80001500 00000400 00003006
210 80001600 00000000 000 00000000 00 00000000 00 10e 80001500 80001500 00000000 00003006
200 80001700 00000000 000 00000000 11 ffffffff 00 000 00000000 80001500 00000300 00003006
240 80001800 00000000 000 00000000 12 11111111 00 108 bfc00380 80001800 00000320 00003006
000 00000000 00000000 000 00000000 10 00400000 00 000 00000000 80001800 00000320 00003006
040 80001a00 00000000 220 80001a04 00 00000000 00 109 bfc00380 80001a04 00000324 00003006

// File: excp.f
logic/excp_pkg.sv
logic/commit_capture.sv
logic/exception_resolve.sv
logic/cp0_regs.sv
logic/redirect_out.sv
logic/excp_top.sv
bench/excp_tb.sv

// File: Bender.yml
package:
  name: excp

sources:
  - logic/excp_pkg.sv
  - logic/commit_capture.sv
  - logic/exception_resolve.sv
  - logic/cp0_regs.sv
  - logic/redirect_out.sv
  - logic/excp_top.sv
  - target: simulation
    files:
      - bench/excp_tb.sv
